//--- common/sys_pkg.sv
/*
 * System package: bus request and response structs, device and register
 * encodings, and the address map of the simple system
 */
package sys_pkg;

  localparam int unsigned DataWidth = 32;
  localparam int unsigned AddrWidth = 32;

  // One request from the host, or the copy forwarded to a device
  typedef struct packed {
    logic                   req;
    logic [AddrWidth-1:0]   addr;
    logic                   we;
    logic [DataWidth/8-1:0] be;
    logic [DataWidth-1:0]   wdata;
  } bus_req_t;

  // Response, valid one cycle after the accepted request
  typedef struct packed {
    logic                 rvalid;
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } bus_rsp_t;

  // Bus targets; DevNone marks an unmapped address
  typedef enum logic [1:0] {
    DevRam,
    DevSimCtrl,
    DevTimer,
    DevNone
  } device_e;

  localparam int unsigned NrDevices = 3;

  // Address map
  localparam logic [AddrWidth-1:0] RamBase     = 32'h0010_0000;
  localparam logic [AddrWidth-1:0] RamMask     = ~32'h0000_0FFF;
  localparam logic [AddrWidth-1:0] SimCtrlBase = 32'h0002_0000;
  localparam logic [AddrWidth-1:0] SimCtrlMask = ~32'h0000_03FF;
  localparam logic [AddrWidth-1:0] TimerBase   = 32'h0003_0000;
  localparam logic [AddrWidth-1:0] TimerMask   = ~32'h0000_03FF;

  // 4 KB of 32-bit words
  localparam int unsigned RamWords = 1024;

  // Timer register word offsets
  typedef enum logic [3:0] {
    TmrTimeLo = 4'h0,
    TmrTimeHi = 4'h4,
    TmrCmpLo  = 4'h8,
    TmrCmpHi  = 4'hC
  } timer_reg_e;

  // Simulation control register offsets
  typedef enum logic [3:0] {
    SimCharOut = 4'h0,
    SimHalt    = 4'h8
  } simctrl_reg_e;

endpackage

//--- source/bus_xbar.sv
/*
 * Single-host bus: decodes the host address, grants at once and
 * steers the device response back, with an error for unmapped space
 */
`timescale 1ns/1ps

module bus_xbar (
  input  logic              clk_i,
  input  logic              rst_i,
  input  sys_pkg::bus_req_t host_req_i,
  output logic              host_gnt_o,
  output sys_pkg::bus_rsp_t host_rsp_o,
  output sys_pkg::bus_req_t dev_req_o [sys_pkg::NrDevices],
  input  sys_pkg::bus_rsp_t dev_rsp_i [sys_pkg::NrDevices]
);

  import sys_pkg::*;

  device_e dev_sel;
  device_e rsp_sel_q;
  logic    rsp_pend_q;

  // Address decode against the map
  always_comb begin
    dev_sel = DevNone;
    if ((host_req_i.addr & RamMask) == RamBase) begin
      dev_sel = DevRam;
    end else if ((host_req_i.addr & SimCtrlMask) == SimCtrlBase) begin
      dev_sel = DevSimCtrl;
    end else if ((host_req_i.addr & TimerMask) == TimerBase) begin
      dev_sel = DevTimer;
    end
  end

  // Only one host, so every request is granted in its own cycle
  assign host_gnt_o = host_req_i.req;

  // Forward the request, raising req only on the decoded device
  always_comb begin
    for (int i = 0; i < NrDevices; i++) begin
      dev_req_o[i]     = host_req_i;
      dev_req_o[i].req = host_req_i.req && (dev_sel == device_e'(i));
    end
  end

  // Remember who took the grant for the response cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_sel_q  <= DevNone;
      rsp_pend_q <= 1'b0;
    end else begin
      rsp_pend_q <= host_req_i.req;
      if (host_req_i.req) begin
        rsp_sel_q <= dev_sel;
      end
    end
  end

  // Response steering
  always_comb begin
    host_rsp_o = '0;
    case (rsp_sel_q)
      DevRam:     host_rsp_o = dev_rsp_i[DevRam];
      DevSimCtrl: host_rsp_o = dev_rsp_i[DevSimCtrl];
      DevTimer:   host_rsp_o = dev_rsp_i[DevTimer];
      default: begin
        // Decode error, data stays zero
        host_rsp_o.rvalid = rsp_pend_q;
        host_rsp_o.err    = rsp_pend_q;
      end
    endcase
  end

endmodule

//--- source/ram_2p.sv
/*
 * Two-port word RAM: byte-enabled read/write data port on A,
 * read-only instruction fetch port on B
 */
`timescale 1ns/1ps

module ram_2p (
  input  logic              clk_i,
  input  logic              rst_i,
  input  sys_pkg::bus_req_t a_req_i,
  output sys_pkg::bus_rsp_t a_rsp_o,
  input  logic              b_req_i,
  input  logic [31:0]       b_addr_i,
  output logic              b_rvalid_o,
  output logic [31:0]       b_rdata_o
);

  import sys_pkg::*;

  logic [DataWidth-1:0] mem [RamWords];

  logic [$clog2(RamWords)-1:0] a_idx;
  logic [$clog2(RamWords)-1:0] b_idx;
  logic                        a_rvalid_q;
  logic [DataWidth-1:0]        a_rdata_q;

  // Word offset inside the RAM region
  assign a_idx = a_req_i.addr[2 +: $clog2(RamWords)];
  assign b_idx = b_addr_i[2 +: $clog2(RamWords)];

  // Port A write, byte lanes picked by be
  always_ff @(posedge clk_i) begin
    if (a_req_i.req && a_req_i.we) begin
      for (int i = 0; i < DataWidth / 8; i++) begin
        if (a_req_i.be[i]) begin
          mem[a_idx][8*i +: 8] <= a_req_i.wdata[8*i +: 8];
        end
      end
    end
  end

  // Read data registered on every request, old word on a same-cycle write
  always_ff @(posedge clk_i) begin
    if (a_req_i.req) begin
      a_rdata_q <= mem[a_idx];
    end
    if (b_req_i) begin
      b_rdata_o <= mem[b_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_rvalid_q <= 1'b0;
      b_rvalid_o <= 1'b0;
    end else begin
      a_rvalid_q <= a_req_i.req;
      b_rvalid_o <= b_req_i;
    end
  end

  assign a_rsp_o = '{rvalid: a_rvalid_q, rdata: a_rdata_q, err: 1'b0};

endmodule

//--- timer/timer.sv
/*
 * Machine timer: free-running 64-bit mtime, 64-bit mtimecmp and a
 * level interrupt once mtime reaches mtimecmp
 */
`timescale 1ns/1ps

module timer (
  input  logic              clk_i,
  input  logic              rst_i,
  input  sys_pkg::bus_req_t req_i,
  output sys_pkg::bus_rsp_t rsp_o,
  output logic              timer_irq_o
);

  import sys_pkg::*;

  logic [63:0]          mtime_q;
  logic [63:0]          mtimecmp_q;
  logic [AddrWidth-1:0] offset;
  timer_reg_e           reg_sel;
  logic                 reg_hit;
  logic                 wr;
  logic [DataWidth-1:0] rd_data;
  logic                 rvalid_q;
  logic                 err_q;
  logic [DataWidth-1:0] rdata_q;

  // Merge write data into a 32-bit half by byte enable
  function automatic logic [DataWidth-1:0] be_merge(
    input logic [DataWidth-1:0]   old_val,
    input logic [DataWidth-1:0]   new_val,
    input logic [DataWidth/8-1:0] be
  );
    logic [DataWidth-1:0] res;
    res = old_val;
    for (int i = 0; i < DataWidth / 8; i++) begin
      if (be[i]) res[8*i +: 8] = new_val[8*i +: 8];
    end
    return res;
  endfunction

  assign offset  = req_i.addr & ~TimerMask;
  assign reg_sel = timer_reg_e'(offset[3:0]);

  // Only the four word offsets are mapped
  always_comb begin
    reg_hit = 1'b0;
    if (offset[AddrWidth-1:4] == '0) begin
      case (reg_sel)
        TmrTimeLo, TmrTimeHi, TmrCmpLo, TmrCmpHi: reg_hit = 1'b1;
        default:                                  reg_hit = 1'b0;
      endcase
    end
  end

  assign wr = req_i.req && req_i.we && reg_hit;

  // A write loads mtime at the grant edge, counting resumes after
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtime_q <= '0;
    end else if (wr && reg_sel == TmrTimeLo) begin
      mtime_q <= {mtime_q[63:32], be_merge(mtime_q[31:0], req_i.wdata, req_i.be)};
    end else if (wr && reg_sel == TmrTimeHi) begin
      mtime_q <= {be_merge(mtime_q[63:32], req_i.wdata, req_i.be), mtime_q[31:0]};
    end else begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtimecmp_q <= '1;
    end else if (wr && reg_sel == TmrCmpLo) begin
      mtimecmp_q[31:0] <= be_merge(mtimecmp_q[31:0], req_i.wdata, req_i.be);
    end else if (wr && reg_sel == TmrCmpHi) begin
      mtimecmp_q[63:32] <= be_merge(mtimecmp_q[63:32], req_i.wdata, req_i.be);
    end
  end

  // Read mux sees mtime before the grant edge updates it
  always_comb begin
    case (reg_sel)
      TmrTimeLo: rd_data = mtime_q[31:0];
      TmrTimeHi: rd_data = mtime_q[63:32];
      TmrCmpLo:  rd_data = mtimecmp_q[31:0];
      TmrCmpHi:  rd_data = mtimecmp_q[63:32];
      default:   rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= (reg_hit && !req_i.we) ? rd_data : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q    <= 1'b0;
      err_q       <= 1'b0;
      timer_irq_o <= 1'b0;
    end else begin
      rvalid_q    <= req_i.req;
      err_q       <= req_i.req && !reg_hit;
      timer_irq_o <= (mtime_q >= mtimecmp_q);
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, rdata: rdata_q, err: err_q};

endmodule

//--- source/sim_ctrl.sv
/*
 * Simulation control: character output strobe and halt flag
 * written by software on the bus
 */
`timescale 1ns/1ps

module sim_ctrl (
  input  logic              clk_i,
  input  logic              rst_i,
  input  sys_pkg::bus_req_t req_i,
  output sys_pkg::bus_rsp_t rsp_o,
  output logic              char_valid_o,
  output logic [7:0]        char_o,
  output logic              halt_o
);

  import sys_pkg::*;

  logic [AddrWidth-1:0] offset;
  simctrl_reg_e         reg_sel;
  logic                 wr;
  logic                 char_wr;
  logic                 rvalid_q;

  assign offset  = req_i.addr & ~SimCtrlMask;
  assign reg_sel = simctrl_reg_e'(offset[3:0]);
  assign wr      = req_i.req && req_i.we && (offset[AddrWidth-1:4] == '0);

  // Character lane is byte 0 only
  assign char_wr = wr && (reg_sel == SimCharOut) && req_i.be[0];

  always_ff @(posedge clk_i) begin
    if (char_wr) begin
      char_o <= req_i.wdata[7:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      char_valid_o <= 1'b0;
      halt_o       <= 1'b0;
      rvalid_q     <= 1'b0;
    end else begin
      char_valid_o <= char_wr;
      rvalid_q     <= req_i.req;
      // Sticky once set
      if (wr && (reg_sel == SimHalt) && req_i.be[0] && req_i.wdata[0]) begin
        halt_o <= 1'b1;
      end
    end
  end

  // Write-only registers, reads give zero
  assign rsp_o = '{rvalid: rvalid_q, rdata: '0, err: 1'b0};

endmodule

//--- source/simple_system.sv
/*
 * Simple system top: single-host bus with RAM, machine timer and
 * simulation control; the core's data and fetch ports are top-level ports
 */
`timescale 1ns/1ps

module simple_system (
  input  logic              clk_i,
  input  logic              rst_i,
  input  sys_pkg::bus_req_t data_req_i,
  output logic              data_gnt_o,
  output sys_pkg::bus_rsp_t data_rsp_o,
  input  logic              instr_req_i,
  input  logic [31:0]       instr_addr_i,
  output logic              instr_rvalid_o,
  output logic [31:0]       instr_rdata_o,
  output logic              timer_irq_o,
  output logic              char_valid_o,
  output logic [7:0]        char_o,
  output logic              halt_o
);

  import sys_pkg::*;

  bus_req_t dev_req [NrDevices];
  bus_rsp_t dev_rsp [NrDevices];

  bus_xbar u_bus (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .host_req_i (data_req_i),
    .host_gnt_o (data_gnt_o),
    .host_rsp_o (data_rsp_o),
    .dev_req_o  (dev_req),
    .dev_rsp_i  (dev_rsp)
  );

  // Shared RAM, port B serves instruction fetch
  ram_2p u_ram (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .a_req_i    (dev_req[DevRam]),
    .a_rsp_o    (dev_rsp[DevRam]),
    .b_req_i    (instr_req_i),
    .b_addr_i   (instr_addr_i),
    .b_rvalid_o (instr_rvalid_o),
    .b_rdata_o  (instr_rdata_o)
  );

  timer u_timer (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (dev_req[DevTimer]),
    .rsp_o       (dev_rsp[DevTimer]),
    .timer_irq_o (timer_irq_o)
  );

  sim_ctrl u_sim_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (dev_req[DevSimCtrl]),
    .rsp_o        (dev_rsp[DevSimCtrl]),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .halt_o       (halt_o)
  );

endmodule

//--- tb/tb_simple_system.sv
/*
 * Simple system testbench: drives the data and fetch ports as a core
 * would and checks every response against a reference model
 */
`timescale 1ns/1ps

module tb_simple_system;

  import sys_pkg::*;

  // Tests take about 1.9k cycles
  localparam logic [31:0] MaxCycles = 32'd5000;
  localparam logic [31:0] TmrGap    = 32'd7;
  localparam logic [31:0] IrqGap    = 32'd5;

  typedef struct packed {
    logic [31:0] due;
    logic [31:0] data;
    logic [31:0] mask;
    logic        err;
  } exp_rsp_t;

  logic        clk = 1'b0;
  logic        rst;
  bus_req_t    data_req;
  logic        data_gnt;
  bus_rsp_t    data_rsp;
  logic        instr_req;
  logic [31:0] instr_addr;
  logic        instr_rvalid;
  logic [31:0] instr_rdata;
  logic        timer_irq;
  logic        char_valid;
  logic [7:0]  char_out;
  logic        halt;

  logic [31:0] model_mem [RamWords];
  exp_rsp_t    data_q [$];
  exp_rsp_t    fetch_q [$];
  exp_rsp_t    d_exp;
  exp_rsp_t    f_exp;
  logic [31:0] cycles = 32'd0;
  logic [31:0] lfsr_state = 32'h61856be9;
  int          char_count = 0;
  logic [7:0]  last_char;
  logic [31:0] r_word;
  logic [31:0] r_idx;
  logic [31:0] w_idx;
  logic [31:0] r_be;
  logic [31:0] r_coin;
  logic [31:0] t_val;
  logic [31:0] wait_cnt;
  logic [31:0] bad_addr [6] = '{32'h0000_0000, 32'h0004_0000, 32'h0010_1000,
                                32'h0003_0010, 32'h0003_0002, 32'h0003_03FC};

  always #50 clk = ~clk;

  simple_system UUT (
    .clk_i          (clk),
    .rst_i          (rst),
    .data_req_i     (data_req),
    .data_gnt_o     (data_gnt),
    .data_rsp_o     (data_rsp),
    .instr_req_i    (instr_req),
    .instr_addr_i   (instr_addr),
    .instr_rvalid_o (instr_rvalid),
    .instr_rdata_o  (instr_rdata),
    .timer_irq_o    (timer_irq),
    .char_valid_o   (char_valid),
    .char_o         (char_out),
    .halt_o         (halt)
  );

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = 32'h0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  // Expected RAM word after a byte-enabled write
  function automatic logic [31:0] merge_word(input logic [31:0] old_word,
                                             input logic [31:0] wdata,
                                             input logic [3:0]  be);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic [31:0] ram_addr(input logic [31:0] word_idx);
    return RamBase | {20'h0, word_idx[9:0], 2'b00};
  endfunction

  // One cycle on both ports, called at a falling edge
  task automatic bus_cycle(input logic req, input logic we, input logic [31:0] addr,
                           input logic [3:0] be, input logic [31:0] wdata,
                           input logic [31:0] tmr_val, input logic f_req,
                           input logic [31:0] f_addr);
    exp_rsp_t e;
    // Fetch sees the word before this cycle's write
    if (f_req) fetch_q.push_back('{cycles + 32'd1, model_mem[f_addr[11:2]], '1, 1'b0});
    if (req) begin
      e = '{cycles + 32'd1, 32'h0, '1, 1'b0};
      if ((addr & RamMask) == RamBase) begin
        e.data = model_mem[addr[11:2]];
        if (we) model_mem[addr[11:2]] = merge_word(model_mem[addr[11:2]], wdata, be);
      end else if ((addr & SimCtrlMask) == SimCtrlBase) begin
        if (we) e.mask = '0;
      end else if ((addr & TimerMask) == TimerBase && addr[9:0] inside
                   {10'h0, 10'h4, 10'h8, 10'hC}) begin
        e.data = tmr_val;
        if (we) e.mask = '0;
      end else begin
        e.err = 1'b1;
      end
      data_q.push_back(e);
    end
    data_req   = '{req: req, addr: addr, we: we, be: be, wdata: wdata};
    instr_req  = f_req;
    instr_addr = f_addr;
    #1;
    check_value("data_gnt", 32'(data_gnt), 32'(req));
    @(negedge clk);
  endtask

  task automatic idle(input logic [31:0] n);
    repeat (n) bus_cycle(1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 32'h0, 1'b0, 32'h0);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 32'd1;
    if (cycles == MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  // Compare process, outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (data_q.size() > 0 && data_q[0].due == cycles) begin
        d_exp = data_q.pop_front();
        check_value("data rvalid", 32'(data_rsp.rvalid), 1);
        check_value("data rdata", data_rsp.rdata & d_exp.mask, d_exp.data & d_exp.mask);
        check_value("data err", 32'(data_rsp.err), 32'(d_exp.err));
      end else begin
        check_value("data rvalid", 32'(data_rsp.rvalid), 0);
      end
      if (fetch_q.size() > 0 && fetch_q[0].due == cycles) begin
        f_exp = fetch_q.pop_front();
        check_value("instr rvalid", 32'(instr_rvalid), 1);
        check_value("instr rdata", instr_rdata, f_exp.data);
      end else begin
        check_value("instr rvalid", 32'(instr_rvalid), 0);
      end
      if (char_valid) begin
        char_count++;
        last_char = char_out;
      end
    end
  end

  initial begin
    rst        = 1'b1;
    data_req   = '0;
    instr_req  = 1'b0;
    instr_addr = 32'h0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_value("timer_irq after reset", 32'(timer_irq), 0);
    check_value("halt after reset", 32'(halt), 0);

    // Fill the whole RAM so every word is known
    for (int i = 0; i < RamWords; i++) begin
      r_word = rand_bits(32);
      bus_cycle(1'b1, 1'b1, ram_addr(i), 4'hF, r_word, 32'h0, 1'b0, 32'h0);
    end

    // Random writes, each followed by three reads, fetches alongside
    for (int n = 0; n < 200; n++) begin
      w_idx  = rand_bits(10);
      r_be   = rand_bits(4);
      r_word = rand_bits(32);
      r_coin = rand_bits(1);
      bus_cycle(1'b1, 1'b1, ram_addr(w_idx), r_be[3:0], r_word, 32'h0, r_coin[0],
                ram_addr(w_idx));
      for (int r = 0; r < 3; r++) begin
        r_idx  = rand_bits(10);
        r_word = rand_bits(10);
        r_coin = rand_bits(1);
        bus_cycle(1'b1, 1'b0, ram_addr(r == 0 ? w_idx : r_idx), 4'hF, 32'h0, 32'h0,
                  r_coin[0], ram_addr(r_word));
      end
    end

    // Unmapped space and bad timer offsets
    for (int i = 0; i < 6; i++) begin
      bus_cycle(1'b1, i[0], bad_addr[i], 4'hF, 32'hDEAD_BEEF, 32'h0, 1'b0, 32'h0);
    end

    // mtime read back TmrGap cycles after a write
    t_val = rand_bits(24);
    bus_cycle(1'b1, 1'b1, TimerBase | 32'(TmrTimeHi), 4'hF, 32'h0, 32'h0, 1'b0, 32'h0);
    bus_cycle(1'b1, 1'b1, TimerBase | 32'(TmrTimeLo), 4'hF, t_val, 32'h0, 1'b0, 32'h0);
    idle(TmrGap - 32'd1);
    bus_cycle(1'b1, 1'b0, TimerBase | 32'(TmrTimeLo), 4'hF, 32'h0, t_val + TmrGap - 32'd1,
              1'b0, 32'h0);

    // Compare IrqGap counts ahead, mtime is t_val + 2 at the last write
    bus_cycle(1'b1, 1'b1, TimerBase | 32'(TmrTimeLo), 4'hF, t_val, 32'h0, 1'b0, 32'h0);
    bus_cycle(1'b1, 1'b1, TimerBase | 32'(TmrCmpHi), 4'hF, 32'h0, 32'h0, 1'b0, 32'h0);
    bus_cycle(1'b1, 1'b1, TimerBase | 32'(TmrCmpLo), 4'hF, t_val + 32'd2 + IrqGap, 32'h0,
              1'b0, 32'h0);
    check_value("timer_irq before match", 32'(timer_irq), 0);
    wait_cnt = 32'd0;
    while (!timer_irq && wait_cnt < IrqGap + 32'd1) begin
      idle(32'd1);
      wait_cnt++;
    end
    check_value("timer_irq at match", 32'(timer_irq), 1);
    bus_cycle(1'b1, 1'b1, TimerBase | 32'(TmrCmpHi), 4'hF, 32'hFFFF_FFFF, 32'h0, 1'b0, 32'h0);
    check_value("timer_irq one cycle after rewrite", 32'(timer_irq), 1);
    bus_cycle(1'b1, 1'b0, TimerBase | 32'(TmrCmpHi), 4'hF, 32'h0, 32'hFFFF_FFFF, 1'b0, 32'h0);
    check_value("timer_irq after rewrite", 32'(timer_irq), 0);

    // Character strobe and halt flag
    r_word = rand_bits(32);
    bus_cycle(1'b1, 1'b1, SimCtrlBase | 32'(SimCharOut), 4'h1, r_word, 32'h0, 1'b0, 32'h0);
    bus_cycle(1'b1, 1'b0, SimCtrlBase | 32'(SimCharOut), 4'hF, 32'h0, 32'h0, 1'b0, 32'h0);
    idle(32'd3);
    check_value("char pulses", 32'(char_count), 1);
    check_value("char value", 32'(last_char), 32'(r_word[7:0]));
    bus_cycle(1'b1, 1'b1, SimCtrlBase | 32'(SimHalt), 4'hF, 32'hFFFF_FFFE, 32'h0, 1'b0, 32'h0);
    idle(32'd2);
    check_value("halt with bit 0 clear", 32'(halt), 0);
    bus_cycle(1'b1, 1'b1, SimCtrlBase | 32'(SimHalt), 4'hF, 32'h1, 32'h0, 1'b0, 32'h0);
    check_value("halt set", 32'(halt), 1);
    idle(32'd4);
    check_value("halt held", 32'(halt), 1);

    if (data_q.size() != 0 || fetch_q.size() != 0) begin
      $display("Some requests never got their response");
      $display("TESTS FAILED");
      $fatal(1, "missing responses");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

//--- flist.f
common/sys_pkg.sv
source/bus_xbar.sv
source/ram_2p.sv
timer/timer.sv
source/sim_ctrl.sv
source/simple_system.sv
tb/tb_simple_system.sv

//--- run.sh
#!/bin/sh
# Build and run with Verilator, pass only if the testbench prints its pass line
cd "$(dirname "$0")" &&
verilator --binary --timescale 1ns/1ps --top-module tb_simple_system -f flist.f &&
./obj_dir/Vtb_simple_system | tee /dev/stderr | grep -q "TESTS PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
